/* exec_pkg.sv */
`default_nettype none

package exec_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [6:0]      opcode_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [6:0]      funct7_t;

    // Major opcodes handled by the stage
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;

    // funct3 for OP and OP-IMM
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // funct3 for conditional branches
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        UNIT_NONE,
        UNIT_ALU,
        UNIT_BRANCH,
        UNIT_JUMP
    } unit_e;

    // Decoded instruction as delivered by the source
    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rd;
        funct3_t   funct3;
        funct7_t   funct7;
        xlen_t     imm;
        xlen_t     pc;
        xlen_t     rs1_val;
        xlen_t     rs2_val;
    } ex_instr_t;

    typedef struct packed {
        unit_e     unit;
        alu_op_e   alu_op;
        xlen_t     op_a;
        xlen_t     op_b;
        reg_addr_t rd;
        funct3_t   funct3;
        opcode_t   opcode;
        xlen_t     pc;
        xlen_t     imm;
        xlen_t     rs1_val;
    } ex_issue_t;

    typedef struct packed {
        reg_addr_t rd;
        logic      rd_we;
        xlen_t     rd_val;
        xlen_t     pc;
        logic      jump;
        xlen_t     jump_pc;
        logic      illegal;
    } ex_result_t;

endpackage

`default_nettype wire

/* ex_issue.sv */
`default_nettype none

module ex_issue import exec_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      flush,
    input  logic      in_valid,
    input  ex_instr_t in_instr,
    output logic      iss_valid,
    output ex_issue_t iss
);

    alu_op_e arith_op;
    unit_e   unit_d;
    alu_op_e alu_op_d;
    xlen_t   op_a_d;
    xlen_t   op_b_d;
    logic    is_op;

    assign is_op = (in_instr.opcode == OPC_OP);

    // funct3 decode shared by OP and OP-IMM, SUB only exists in OP
    always_comb begin
        case (in_instr.funct3)
            F3_ADD:  arith_op = (is_op && in_instr.funct7[5]) ? ALU_SUB : ALU_ADD;
            F3_SLL:  arith_op = ALU_SLL;
            F3_SLT:  arith_op = ALU_SLT;
            F3_SLTU: arith_op = ALU_SLTU;
            F3_XOR:  arith_op = ALU_XOR;
            F3_SR:   arith_op = in_instr.funct7[5] ? ALU_SRA : ALU_SRL;
            F3_OR:   arith_op = ALU_OR;
            F3_AND:  arith_op = ALU_AND;
            default: arith_op = ALU_ADD;
        endcase
    end

    // Unit select and operand muxing
    always_comb begin
        unit_d   = UNIT_NONE;
        alu_op_d = ALU_ADD;
        op_a_d   = in_instr.rs1_val;
        op_b_d   = in_instr.imm;
        case (in_instr.opcode)
            OPC_OP: begin
                unit_d   = UNIT_ALU;
                alu_op_d = arith_op;
                op_b_d   = in_instr.rs2_val;
            end
            OPC_OP_IMM: begin
                unit_d   = UNIT_ALU;
                alu_op_d = arith_op;
            end
            OPC_LUI: begin
                unit_d = UNIT_ALU;
                op_a_d = '0;
            end
            OPC_AUIPC: begin
                unit_d = UNIT_ALU;
                op_a_d = in_instr.pc;
            end
            OPC_BRANCH: begin
                // Compare rs1 against rs2 for the flags
                unit_d   = UNIT_BRANCH;
                alu_op_d = ALU_SUB;
                op_b_d   = in_instr.rs2_val;
            end
            OPC_JAL, OPC_JALR: begin
                unit_d = UNIT_JUMP;
            end
            default: begin
                unit_d = UNIT_NONE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= in_valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            iss.unit    <= unit_d;
            iss.alu_op  <= alu_op_d;
            iss.op_a    <= op_a_d;
            iss.op_b    <= op_b_d;
            iss.rd      <= in_instr.rd;
            iss.funct3  <= in_instr.funct3;
            iss.opcode  <= in_instr.opcode;
            iss.pc      <= in_instr.pc;
            iss.imm     <= in_instr.imm;
            iss.rs1_val <= in_instr.rs1_val;
        end
    end

    a_iss_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(iss_valid)
    );

endmodule

`default_nettype wire

/* int_alu.sv */
`default_nettype none

module int_alu import exec_pkg::*; (
    input  xlen_t   op_a,
    input  xlen_t   op_b,
    input  alu_op_e alu_op,
    output xlen_t   alu_result,
    output logic    lt,
    output logic    ltu,
    output logic    eq
);

    logic [4:0] shamt;
    xlen_t      sum;
    xlen_t      diff;
    xlen_t      shl;
    xlen_t      shr_l;
    xlen_t      shr_a;

    assign shamt = op_b[4:0];

    // Comparison flags, also used by the branch unit
    assign lt  = $signed(op_a) < $signed(op_b);
    assign ltu = op_a < op_b;
    assign eq  = (op_a == op_b);

    assign sum   = op_a + op_b;
    assign diff  = op_a - op_b;
    assign shl   = op_a << shamt;
    assign shr_l = op_a >> shamt;
    assign shr_a = xlen_t'($signed(op_a) >>> shamt);

    always_comb begin
        case (alu_op)
            ALU_ADD: begin
                alu_result = sum;
            end
            ALU_SUB: begin
                alu_result = diff;
            end
            ALU_SLL: begin
                alu_result = shl;
            end
            ALU_SLT: begin
                alu_result = {{(XLEN-1){1'b0}}, lt};
            end
            ALU_SLTU: begin
                alu_result = {{(XLEN-1){1'b0}}, ltu};
            end
            ALU_XOR: begin
                alu_result = op_a ^ op_b;
            end
            ALU_SRL: begin
                alu_result = shr_l;
            end
            ALU_SRA: begin
                alu_result = shr_a;
            end
            ALU_OR: begin
                alu_result = op_a | op_b;
            end
            ALU_AND: begin
                alu_result = op_a & op_b;
            end
            default: begin
                alu_result = sum;
            end
        endcase
    end

endmodule

`default_nettype wire

/* branch_unit.sv */
`default_nettype none

module branch_unit import exec_pkg::*; (
    input  ex_issue_t iss,
    input  logic      lt,
    input  logic      ltu,
    input  logic      eq,
    output logic      br_jump,
    output xlen_t     br_target,
    output xlen_t     br_link
);

    logic  is_jalr;
    logic  cond;
    xlen_t base;
    xlen_t sum;

    assign is_jalr = (iss.opcode == OPC_JALR);

    // JALR adds to rs1, everything else is pc relative
    assign base = is_jalr ? iss.rs1_val : iss.pc;
    assign sum  = base + iss.imm;

    assign br_link = iss.pc + 32'd4;

    always_comb begin
        case (iss.funct3)
            F3_BEQ:  cond = eq;
            F3_BNE:  cond = !eq;
            F3_BLT:  cond = lt;
            F3_BGE:  cond = !lt;
            F3_BLTU: cond = ltu;
            F3_BGEU: cond = !ltu;
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        case (iss.unit)
            UNIT_BRANCH: begin
                br_jump   = cond;
                br_target = sum;
            end
            UNIT_JUMP: begin
                br_jump   = 1'b1;
                br_target = {sum[XLEN-1:1], 1'b0};
            end
            default: begin
                br_jump   = 1'b0;
                br_target = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* ex_result.sv */
`default_nettype none

module ex_result import exec_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,
    input  logic       iss_valid,
    input  ex_issue_t  iss,
    input  xlen_t      alu_result,
    input  xlen_t      br_target,
    input  xlen_t      br_link,
    input  logic       br_jump,
    output logic       out_valid,
    output ex_result_t out_res
);

    logic [3:0] unit_oh;
    logic       writes_rd;
    ex_result_t res_d;

    // One bit per unit, indexed by the enum value
    always_comb begin
        unit_oh            = '0;
        unit_oh[iss.unit]  = 1'b1;
    end

    assign writes_rd = unit_oh[UNIT_ALU] | unit_oh[UNIT_JUMP];

    always_comb begin
        res_d.rd      = iss.rd;
        res_d.rd_we   = writes_rd && (iss.rd != '0);
        res_d.rd_val  = ({XLEN{unit_oh[UNIT_ALU]}} & alu_result) |
                        ({XLEN{unit_oh[UNIT_JUMP]}} & br_link);
        res_d.pc      = iss.pc;
        res_d.jump    = br_jump;
        res_d.jump_pc = br_target;
        res_d.illegal = unit_oh[UNIT_NONE];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_res   <= '0;
        end else begin
            out_valid <= iss_valid && !flush;
            if (iss_valid) begin
                out_res <= res_d;
            end
        end
    end

    // Unit handed over by the issue stage must agree with the opcode
    a_unit_decode: assert property (
        @(posedge clk) disable iff (!rst_n)
        iss_valid |-> (unit_oh[UNIT_BRANCH] == (iss.opcode == OPC_BRANCH)) &&
                      (unit_oh[UNIT_JUMP] == (iss.opcode == OPC_JAL ||
                                              iss.opcode == OPC_JALR))
    );

endmodule

`default_nettype wire

/* ex_top.sv */
`default_nettype none

module ex_top import exec_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,
    input  logic       in_valid,
    input  ex_instr_t  in_instr,
    output logic       out_valid,
    output ex_result_t out_res
);

    logic      iss_valid;
    ex_issue_t iss;

    xlen_t alu_result;
    logic  lt;
    logic  ltu;
    logic  eq;

    logic  br_jump;
    xlen_t br_target;
    xlen_t br_link;

    ex_issue i_issue (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .iss_valid (iss_valid),
        .iss       (iss)
    );

    int_alu i_alu (
        .op_a       (iss.op_a),
        .op_b       (iss.op_b),
        .alu_op     (iss.alu_op),
        .alu_result (alu_result),
        .lt         (lt),
        .ltu        (ltu),
        .eq         (eq)
    );

    branch_unit i_branch (
        .iss       (iss),
        .lt        (lt),
        .ltu       (ltu),
        .eq        (eq),
        .br_jump   (br_jump),
        .br_target (br_target),
        .br_link   (br_link)
    );

    ex_result i_result (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .iss_valid  (iss_valid),
        .iss        (iss),
        .alu_result (alu_result),
        .br_target  (br_target),
        .br_link    (br_link),
        .br_jump    (br_jump),
        .out_valid  (out_valid),
        .out_res    (out_res)
    );

endmodule

`default_nettype wire

/* tb_ex_model.svh */
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

// Expected result record of one instruction, RV32I semantics
function automatic ex_result_t expected_result(input ex_instr_t ins);
    ex_result_t r;
    xlen_t      a;
    xlen_t      b;
    r    = '0;
    r.rd = ins.rd;
    r.pc = ins.pc;
    a    = ins.rs1_val;
    b    = (ins.opcode == OPC_OP || ins.opcode == OPC_BRANCH) ? ins.rs2_val : ins.imm;
    case (ins.opcode)
        OPC_OP, OPC_OP_IMM: begin
            case (ins.funct3)
                3'b000: r.rd_val = (ins.opcode == OPC_OP && ins.funct7[5]) ? a - b : a + b;
                3'b001: r.rd_val = a << b[4:0];
                3'b010: r.rd_val = {31'b0, $signed(a) < $signed(b)};
                3'b011: r.rd_val = {31'b0, a < b};
                3'b100: r.rd_val = a ^ b;
                3'b101: begin
                    if (ins.funct7[5]) begin
                        r.rd_val = $signed(a) >>> b[4:0];
                    end else begin
                        r.rd_val = a >> b[4:0];
                    end
                end
                3'b110: r.rd_val = a | b;
                default: r.rd_val = a & b;
            endcase
            r.rd_we = (ins.rd != 5'd0);
        end
        OPC_LUI, OPC_AUIPC: begin
            r.rd_val = (ins.opcode == OPC_LUI) ? ins.imm : ins.pc + ins.imm;
            r.rd_we  = (ins.rd != 5'd0);
        end
        OPC_BRANCH: begin
            case (ins.funct3)
                3'b000: r.jump = (a == b);
                3'b001: r.jump = (a != b);
                3'b100: r.jump = $signed(a) < $signed(b);
                3'b101: r.jump = $signed(a) >= $signed(b);
                3'b110: r.jump = a < b;
                3'b111: r.jump = a >= b;
                default: r.jump = 1'b0;
            endcase
            r.jump_pc = ins.pc + ins.imm;
        end
        OPC_JAL, OPC_JALR: begin
            r.rd_val     = ins.pc + 32'd4;
            r.rd_we      = (ins.rd != 5'd0);
            r.jump       = 1'b1;
            r.jump_pc    = ((ins.opcode == OPC_JALR) ? a : ins.pc) + ins.imm;
            r.jump_pc[0] = 1'b0;
        end
        default: r.illegal = 1'b1;
    endcase
    return r;
endfunction

`endif

/* tb_ex_top.sv */
`default_nettype none

module tb_ex_top import exec_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DRAIN_LIMIT = 20;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       flush;
    logic       in_valid;
    ex_instr_t  in_instr;
    logic       out_valid;
    ex_result_t out_res;

    int         seed = 32'h9f25;
    int         cyc = 0;
    ex_result_t exp_q[$];
    int         due_q[$];
    ex_result_t exp_res;
    int         due;

    `include "tb_ex_model.svh"

    ex_top i_ex_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .out_valid (out_valid),
        .out_res   (out_res)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic compare_record(input ex_result_t got, input ex_result_t exp);
        check_value("out_res.rd", 32'(got.rd), 32'(exp.rd));
        check_value("out_res.rd_we", 32'(got.rd_we), 32'(exp.rd_we));
        check_value("out_res.rd_val", got.rd_val, exp.rd_val);
        check_value("out_res.pc", got.pc, exp.pc);
        check_value("out_res.jump", 32'(got.jump), 32'(exp.jump));
        check_value("out_res.jump_pc", got.jump_pc, exp.jump_pc);
        check_value("out_res.illegal", 32'(got.illegal), 32'(exp.illegal));
    endtask

    // Kinds: 0 OP, 1 OP-IMM, 2 LUI, 3 AUIPC, 4 branch, 5 JAL, 6 JALR, 7 unknown
    task automatic make_instr(input int kind, output ex_instr_t ins);
        logic [31:0] r0;
        logic [31:0] r1;
        r0          = $random(seed);
        r1          = $random(seed);
        ins         = '0;
        ins.rd      = (r0[15:13] == 3'd0) ? 5'd0 : r0[4:0];
        ins.funct3  = r0[7:5];
        ins.imm     = {{20{r1[11]}}, r1[11:0]};
        ins.pc      = $random(seed);
        ins.pc[1:0] = 2'b00;
        ins.rs1_val = $random(seed);
        ins.rs2_val = $random(seed);
        case (kind)
            0: begin
                ins.opcode = OPC_OP;
                if (ins.funct3 == 3'b000 || ins.funct3 == 3'b101) begin
                    ins.funct7 = {1'b0, r0[8], 5'b0};
                end
            end
            1: begin
                ins.opcode = OPC_OP_IMM;
                if (ins.funct3 == 3'b001) begin
                    ins.imm = {27'b0, r1[4:0]};
                end else if (ins.funct3 == 3'b101) begin
                    ins.funct7 = {1'b0, r0[8], 5'b0};
                    ins.imm    = {20'b0, ins.funct7, r1[4:0]};
                end
            end
            2, 3: begin
                ins.opcode = (kind == 2) ? OPC_LUI : OPC_AUIPC;
                ins.imm    = {r1[31:12], 12'b0};
            end
            4: begin
                ins.opcode = OPC_BRANCH;
                // Map the two unused encodings onto BLTU/BGEU
                if (ins.funct3[2:1] == 2'b01) begin
                    ins.funct3[2] = 1'b1;
                end
                ins.imm = {{19{r1[12]}}, r1[12:1], 1'b0};
                if (r0[8]) begin
                    ins.rs2_val = ins.rs1_val;
                end
            end
            5: begin
                ins.opcode = OPC_JAL;
                ins.imm    = {{11{r1[20]}}, r1[20:1], 1'b0};
            end
            6: ins.opcode = OPC_JALR;
            default: begin
                // Load, store, system, fence
                ins.opcode = r0[9] ? (r0[10] ? 7'b0000011 : 7'b0100011)
                                   : (r0[10] ? 7'b1110011 : 7'b0001111);
            end
        endcase
    endtask

    task drive_instr(input int kind);
        ex_instr_t ins;
        @(negedge clk);
        make_instr(kind, ins);
        flush    = 1'b0;
        in_valid = 1'b1;
        in_instr = ins;
        exp_q.push_back(expected_result(ins));
        due_q.push_back(cyc + 2);
    endtask

    task drive_idle();
        @(negedge clk);
        flush    = 1'b0;
        in_valid = 1'b0;
    endtask

    // Anything not visible at the output yet is dropped, the strobe too
    task drive_flush();
        ex_instr_t ins;
        logic [31:0] r;
        @(negedge clk);
        make_instr(0, ins);
        r        = $random(seed);
        flush    = 1'b1;
        in_valid = r[0];
        in_instr = ins;
        while (due_q.size() != 0 && due_q[due_q.size()-1] > cyc) begin
            due_q.delete(due_q.size() - 1);
            exp_q.delete(exp_q.size() - 1);
        end
    endtask

    task wait_drain();
        int waited;
        waited = 0;
        while (due_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > DRAIN_LIMIT) begin
                abort_run("timeout waiting for outstanding results");
            end
        end
    endtask

    // Output monitor on the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            if (cyc > 0) begin
                check_value("out_valid", 32'(out_valid), 32'd0);
            end
        end else if (out_valid) begin
            if (due_q.size() == 0) begin
                abort_run("out_valid high with no instruction in flight");
            end else begin
                due     = due_q.pop_front();
                exp_res = exp_q.pop_front();
                if (due != cyc) begin
                    abort_run($sformatf("result came at cycle %0d instead of %0d", cyc, due));
                end
                compare_record(out_res, exp_res);
            end
        end else if (due_q.size() != 0 && due_q[0] <= cyc) begin
            abort_run($sformatf("no result for the instruction due at cycle %0d", due_q[0]));
        end
    end

    initial begin
        logic [31:0] r;
        rst_n    = 1'b0;
        flush    = 1'b0;
        in_valid = 1'b0;
        in_instr = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        compare_record(out_res, '0);

        // Every kind back to back
        for (int k = 0; k < 8; k++) begin
            for (int n = 0; n < 40; n++) begin
                drive_instr(k);
            end
        end
        drive_idle();
        wait_drain();

        // Mixed traffic with gaps and flushes
        for (int n = 0; n < 400; n++) begin
            r = $random(seed);
            if (r[3:0] == 4'd0) begin
                drive_flush();
            end else if (r[5:4] == 2'd0) begin
                drive_idle();
            end else begin
                drive_instr(int'(r[8:6]));
            end
        end
        drive_idle();
        wait_drain();
        repeat (4) @(negedge clk);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
exec_pkg.sv
ex_issue.sv
int_alu.sv
branch_unit.sv
ex_result.sv
ex_top.sv
tb_ex_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_ex_top -f all.f -o sim_ex
./obj_dir/sim_ex | tee sim.log
if grep -q "^RESULT: PASS$" sim.log; then
    exit 0
fi
exit 1
